/* arrayHeap.f */
+incdir+verilog
+incdir+tb
verilog/heapPkg.sv
verilog/heapAllocator.sv
verilog/arrayStore.sv
verilog/arraySearch.sv
verilog/elementAlu.sv
verilog/arrayHeap.sv
tb/arrayHeapTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := arrayHeapTb
FILELIST  := arrayHeap.f
OBJDIR    := obj_dir
VFLAGS    := --binary --assert --timescale 1ns/1ps -j 0 --top-module $(TOP) --Mdir $(OBJDIR)

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a nonzero exit
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* tb/heapTasks.svh */
/*
  Array heap testbench tasks
  Command driving, response checks and the stop on the first error
*/

`ifndef HEAP_TASKS_SVH
`define HEAP_TASKS_SVH

// --------------------
// Failure stop
// --------------------
task automatic abortRun();
  $display("*** FAILED ***");
  $fatal(1, "Testbench stopped at the first error");
endtask

task automatic checkValue(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
  if (actual !== expected) begin                          // X counts as a mismatch
    $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    abortRun();
  end
endtask

// --------------------
// Command driving
// --------------------
// Starts at a falling edge and returns at the next one, with resp stable
task automatic issue(input heapOp_t op, input int arrayNum, input int idx, input int value);
  cmd.op    = op;
  cmd.array = `HEAP_ARRAY_BITS'(arrayNum);
  cmd.index = `HEAP_INDEX_BITS'(idx);
  cmd.data  = `HEAP_DATA_BITS'(value);
  @(posedge clock);                                       // DUT takes the command
  @(negedge clock);                                       // Response settled
  lastResp = resp;
  cmd      = '0;                                          // Nop until the next command
endtask

task automatic expectError(input heapOp_t op, input int arrayNum, input int idx,
                           input int value, input heapError_t expErr, input string label);
  issue(op, arrayNum, idx, value);
  checkValue($sformatf("%s resp.error", label), 32'(lastResp.error), 32'(expErr));
endtask

task automatic expectData(input heapOp_t op, input int arrayNum, input int idx,
                          input int value, input int expData, input string label);
  issue(op, arrayNum, idx, value);
  checkValue($sformatf("%s resp.error", label), 32'(lastResp.error), 32'(errNone));
  checkValue($sformatf("%s resp.data", label), 32'(lastResp.data), expData);
endtask

// Response must be back at zero once reset is released
task automatic waitResetRelease();
  int cycles;
  cycles = 0;
  while (cycles < RESET_WAIT_CYCLES && !(resetN === 1'b1 && resp === '0)) begin
    @(negedge clock);
    cycles++;
  end
  if (!(resetN === 1'b1 && resp === '0)) begin
    $display("Reset did not bring the response back to zero in time");
    abortRun();
  end
endtask

`endif

/* tb/arrayHeapTb.sv */
/*
  Array heap testbench
  Directed tests of allocation, element access, stack use, search,
  element arithmetic, Clear and asynchronous reset
*/

`timescale 1ns/1ps
`include "heap_cfg.svh"

module arrayHeapTb import heapPkg::*; ();

  localparam int CLOCK_HALF_NS     = 50;                  // 100 ns period
  localparam int RESET_WAIT_CYCLES = 10;
  localparam int WATCHDOG_NS       = 1000000;             // Far beyond the test length
  localparam int DATA_MASK         = (1 << `HEAP_DATA_BITS) - 1;

  logic      clock = 1'b0;
  logic      resetN;
  heapCmd_t  cmd;
  heapResp_t resp;
  heapResp_t lastResp;                                    // Response of last command
  int        seed = 32'h6c9db484;

  arrayHeap i_dut (.clock, .resetN, .cmd, .resp);

  `include "heapTasks.svh"

  // --------------------
  // Clock and watchdog
  // --------------------
  initial begin
    forever #(CLOCK_HALF_NS) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Simulation ran past its time limit");
    abortRun();
  end

  function automatic int randomData();
    return $random(seed) & DATA_MASK;                     // One element's worth
  endfunction

  // New element value for each arithmetic op, wrapped to the data width
  function automatic int arithResult(input heapOp_t op, input int x, input int y);
    int r;
    case (op)
      opAdd, opAddAfter: r = x + y;
      opSub, opSubAfter: r = x - y;
      opShiftLeft:       r = x << y;
      opShiftRight:      r = x >> y;
      opOr:              r = x | y;
      opXor:             r = x ^ y;
      opAnd:             r = x & y;
      opNot:             r = ~x;
      default:           r = x;
    endcase
    return r & DATA_MASK;
  endfunction

  // Asserted between edges so only the async path clears resp
  task automatic pulseReset(input int delayNs);
    #(delayNs);
    resetN = 1'b0;
    #1;
    checkValue("resp during reset", 32'(resp), 0);
    repeat (3) @(negedge clock);
    resetN = 1'b1;
    waitResetRelease();
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic allocateAndReuse();
    expectError(opClear, 0, 0, 0, errNone, "Clear");
    for (int i = 0; i < `HEAP_ARRAYS; i++) begin
      expectData(opAlloc, 0, 0, 0, i, "Alloc fresh");     // Counter order
    end
    expectError(opAlloc, 0, 0, 0, errNoMemory, "Alloc with heap full");
    expectError(opFree, 1, 0, 0, errNone, "Free 1");
    expectError(opFree, 3, 0, 0, errNone, "Free 3");
    expectData(opAlloc, 0, 0, 0, 3, "Alloc reuse");       // Newest freed first
    expectData(opAlloc, 0, 0, 0, 1, "Alloc reuse");
    expectError(opFree, 2, 0, 0, errNone, "Free 2");
    expectError(opFree, 2, 0, 0, errFreed, "Double free");
    expectError(opClear, 0, 0, 0, errNone, "Clear");
    expectData(opAlloc, 0, 0, 0, 0, "Alloc after Clear");
    expectError(opRead, 2, 0, 0, errNotAllocated, "Read unallocated");
    expectError(opFree, 3, 0, 0, errNotAllocated, "Free unallocated");
  endtask

  task automatic writeReadSize();
    int v0;
    int v2;
    v0 = randomData();
    v2 = randomData();
    expectData(opWrite, 0, 0, v0, v0, "Write 0");         // Echo
    expectData(opWrite, 0, 2, v2, v2, "Write 2");
    expectData(opSize, 0, 0, 0, 3, "Size");               // Highest index plus one
    expectData(opRead, 0, 0, 0, v0, "Read 0");
    expectData(opRead, 0, 2, 0, v2, "Read 2");
    expectError(opRead, 0, 3, 0, errOutOfBounds, "Read 3");
    checkValue("Read 3 resp.data", 32'(lastResp.data), v2);  // Held from Read 2
  endtask

  task automatic pushPop();
    int pushed [`HEAP_ARRAY_LENGTH];
    expectData(opAlloc, 0, 0, 0, 1, "Alloc");
    for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
      pushed[i] = randomData();
      expectError(opPush, 1, 0, pushed[i], errNone, "Push");
    end
    expectError(opPush, 1, 0, 0, errFull, "Push on full");
    for (int i = `HEAP_ARRAY_LENGTH - 1; i >= 0; i--) begin
      expectData(opPop, 1, 0, 0, pushed[i], "Pop");       // Reverse order
    end
    expectError(opPop, 1, 0, 0, errEmpty, "Pop on empty");
  endtask

  task automatic searchRow();
    expectData(opAlloc, 0, 0, 0, 2, "Alloc");
    expectData(opWrite, 2, 0, 10, 10, "Write 10");
    expectData(opWrite, 2, 1, 20, 20, "Write 20");
    expectData(opWrite, 2, 2, 30, 30, "Write 30");
    expectData(opGreater, 2, 0, 15, 2, "Greater 15");
    expectData(opLess, 2, 0, 25, 2, "Less 25");
    expectData(opIndex, 2, 0, 20, 2, "Index 20");         // One past position 1
    expectData(opIndex, 2, 0, 99, 0, "Index 99");
    expectData(opPop, 2, 0, 0, 30, "Pop");
    expectData(opGreater, 2, 0, 15, 1, "Greater 15 after Pop");
  endtask

  task automatic applyArithmetic();
    heapOp_t op;
    int      x;
    int      y;
    int      after;
    expectData(opAlloc, 0, 0, 0, 3, "Alloc");
    for (int k = int'(opAdd); k <= int'(opNot); k++) begin
      op = heapOp_t'(k);
      x  = randomData();
      y  = randomData();
      if (op == opShiftLeft || op == opShiftRight) begin
        y = y & 7;                                        // Keep some bits in range
      end
      after = arithResult(op, x, y);
      expectData(opWrite, 3, 0, x, x, "Write operand");
      if (op == opAddAfter || op == opSubAfter) begin
        expectData(op, 3, 0, y, x, op.name());            // Old value reported
      end else begin
        expectData(op, 3, 0, y, after, op.name());
      end
      expectData(opRead, 3, 0, 0, after, "Read back");
    end
  endtask

  task automatic clearAndReset();
    expectError(opClear, 0, 0, 0, errNone, "Clear");
    expectError(opRead, 0, 0, 0, errNotAllocated, "Read after Clear");
    expectData(opAlloc, 0, 0, 0, 0, "Alloc after Clear");
    expectData(opSize, 0, 0, 0, 0, "Size after Clear");
    expectData(opAlloc, 0, 0, 0, 1, "Alloc");
    expectData(opWrite, 1, 1, 'h5a5, 'h5a5, "Write");      // Nonzero resp before reset
    pulseReset(20);
    expectError(opRead, 0, 0, 0, errNotAllocated, "Read after reset");
    expectData(opAlloc, 0, 0, 0, 0, "Alloc after reset");
    expectData(opSize, 0, 0, 0, 0, "Size after reset");
  endtask

  // --------------------
  // Sequence
  // --------------------
  initial begin
    cmd      = '0;
    resetN   = 1'b0;
    lastResp = '0;
    repeat (3) @(negedge clock);                          // Reset for 3 cycles
    resetN = 1'b1;
    waitResetRelease();
    allocateAndReuse();
    writeReadSize();
    pushPop();
    searchRow();
    applyArithmetic();
    clearAndReset();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* verilog/arrayHeap.sv */
/*
  Array heap top
  Checks each command against allocation and size, picks the error
  and the returned value, and registers the response one cycle later
*/

`timescale 1ns/1ps
`include "heap_cfg.svh"

module arrayHeap import heapPkg::*; (
  input  logic      clock,
  input  logic      resetN,
  input  heapCmd_t  cmd,                                  // One command per clock
  output heapResp_t resp                                  // Result of previous command
);

  logic [`HEAP_ARRAY_BITS-1:0] allocNumber;
  logic                        allocFail;
  logic                        isFresh;
  logic                        isAllocated;
  heapRow_t                    row;
  logic [`HEAP_SIZE_BITS-1:0]  size;
  logic [`HEAP_SIZE_BITS-1:0]  popSlot;                   // Last live element
  logic [`HEAP_DATA_BITS-1:0]  element;
  logic [`HEAP_DATA_BITS-1:0]  searchResult;
  logic [`HEAP_DATA_BITS-1:0]  aluValue;
  logic [`HEAP_DATA_BITS-1:0]  aluReported;
  logic [`HEAP_DATA_BITS-1:0]  respData;
  heapError_t                  error;
  logic                        commit;
  logic                        returnsValue;
  logic                        isArith;
  logic                        needsArray;
  logic                        needsIndex;

  heapAllocator i_allocator (.clock, .resetN, .cmd, .commit,
                             .allocNumber, .allocFail, .isFresh, .isAllocated);

  arrayStore i_store (.clock, .resetN, .cmd, .commit, .allocNumber,
                      .aluValue, .row, .size);

  arraySearch i_search (.row, .size, .key(cmd.data), .op(cmd.op), .result(searchResult));

  elementAlu i_alu (.op(cmd.op), .element, .operand(cmd.data),
                    .newValue(aluValue), .reported(aluReported));

  assign element = row[cmd.index];
  assign popSlot = size - 1'b1;
  assign isArith = cmd.op inside {opAdd, opAddAfter, opSub, opSubAfter,
                                  opShiftLeft, opShiftRight,
                                  opOr, opXor, opAnd, opNot};
  assign needsArray = !(cmd.op inside {opNop, opClear, opAlloc});
  assign needsIndex = cmd.op == opRead || isArith;

  // --------------------
  // Access checks in priority order
  // --------------------
  always_comb begin
    error = errNone;
    if (needsArray && isFresh) begin
      error = errNotAllocated;
    end else if (needsArray && !isAllocated) begin
      error = errFreed;                                   // Also catches double free
    end else if (needsIndex && {1'b0, cmd.index} >= size) begin
      error = errOutOfBounds;
    end else if (cmd.op == opPush && size == `HEAP_ARRAY_LENGTH) begin
      error = errFull;
    end else if (cmd.op == opPop && size == '0) begin
      error = errEmpty;
    end else if (cmd.op == opAlloc && allocFail) begin
      error = errNoMemory;
    end
  end

  assign commit = error == errNone && cmd.op != opNop;

  // --------------------
  // Returned value
  // --------------------
  always_comb begin
    returnsValue = 1'b1;
    respData     = aluReported;
    case (cmd.op)
      opAlloc:                    respData = `HEAP_DATA_BITS'(allocNumber);
      opRead:                     respData = element;
      opSize:                     respData = `HEAP_DATA_BITS'(size);
      opWrite:                    respData = cmd.data;    // Echo
      opPop:                      respData = row[popSlot[`HEAP_INDEX_BITS-1:0]];
      opIndex, opLess, opGreater: respData = searchResult;
      default:                    returnsValue = isArith; // Arith keeps ALU value
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      resp <= '{data: '0, error: errNone};
    end else begin
      if (cmd.op != opNop) begin
        resp.error <= error;
      end
      if (commit && returnsValue) begin
        resp.data <= respData;                            // Else data holds
      end
    end
  end

  respKnown: assert property (@(posedge clock) disable iff (!resetN)
    !$isunknown(resp.error));

endmodule

/* verilog/elementAlu.sv */
/*
  Element ALU
  In-place arithmetic on one element, giving the value to store
  and the value to report
*/

`timescale 1ns/1ps
`include "heap_cfg.svh"

module elementAlu import heapPkg::*; (
  input  heapOp_t                     op,
  input  logic [`HEAP_DATA_BITS-1:0]  element,            // Current element
  input  logic [`HEAP_DATA_BITS-1:0]  operand,            // From cmd.data
  output logic [`HEAP_DATA_BITS-1:0]  newValue,           // Written back
  output logic [`HEAP_DATA_BITS-1:0]  reported            // Returned in resp
);

  logic reportOld;                                        // After ops return old value

  // --------------------
  // Operation
  // --------------------
  always_comb begin
    case (op)
      opAdd, opAddAfter: newValue = element + operand;    // Wraps at data width
      opSub, opSubAfter: newValue = element - operand;
      opShiftLeft:       newValue = element << operand;
      opShiftRight:      newValue = element >> operand;
      opOr:              newValue = element | operand;
      opXor:             newValue = element ^ operand;
      opAnd:             newValue = element & operand;
      opNot:             newValue = ~element;             // Operand ignored
      default:           newValue = element;              // Leave untouched
    endcase
  end

  assign reportOld = op == opAddAfter || op == opSubAfter;
  assign reported  = reportOld ? element : newValue;

endmodule

/* verilog/arraySearch.sv */
/*
  Array search
  Index of a key and counts of smaller and larger elements over
  the live part of one array
*/

`timescale 1ns/1ps
`include "heap_cfg.svh"

module arraySearch import heapPkg::*; (
  input  heapRow_t                    row,                // Whole array
  input  logic [`HEAP_SIZE_BITS-1:0]  size,               // Live elements
  input  logic [`HEAP_DATA_BITS-1:0]  key,                // Value searched for
  input  heapOp_t                     op,
  output logic [`HEAP_DATA_BITS-1:0]  result
);

  logic [`HEAP_SIZE_BITS-1:0] matchPos;                   // One past last match
  logic [`HEAP_SIZE_BITS-1:0] lessCount;
  logic [`HEAP_SIZE_BITS-1:0] greaterCount;

  // --------------------
  // Scan live elements
  // --------------------
  always_comb begin
    matchPos     = '0;
    lessCount    = '0;
    greaterCount = '0;
    for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
      if (i < size) begin                                 // Skip unused tail
        if (row[i] == key) begin
          matchPos = `HEAP_SIZE_BITS'(i + 1);              // Highest match wins
        end
        if (row[i] < key) begin
          lessCount = lessCount + 1'b1;
        end
        if (row[i] > key) begin
          greaterCount = greaterCount + 1'b1;
        end
      end
    end
  end

  always_comb begin
    case (op)
      opIndex:   result = `HEAP_DATA_BITS'(matchPos);
      opLess:    result = `HEAP_DATA_BITS'(lessCount);
      opGreater: result = `HEAP_DATA_BITS'(greaterCount);
      default:   result = '0;                             // Not a search
    endcase
  end

endmodule

/* verilog/arrayStore.sv */
/*
  Array storage
  Element memory and the size of every array, changed only by
  commands that passed the access checks
*/

`timescale 1ns/1ps
`include "heap_cfg.svh"

module arrayStore import heapPkg::*; (
  input  logic                         clock,
  input  logic                         resetN,
  input  heapCmd_t                     cmd,
  input  logic                         commit,            // Command passed all checks
  input  logic [`HEAP_ARRAY_BITS-1:0]  allocNumber,       // Array being allocated
  input  logic [`HEAP_DATA_BITS-1:0]   aluValue,          // Result of element arithmetic
  output heapRow_t                     row,               // Addressed array
  output logic [`HEAP_SIZE_BITS-1:0]   size               // Its current size
);

  heapRow_t                    rows  [`HEAP_ARRAYS];      // Element memory
  logic [`HEAP_SIZE_BITS-1:0]  sizes [`HEAP_ARRAYS];      // Live elements per array
  logic                        isArith;
  logic                        storeEnable;
  logic [`HEAP_SIZE_BITS-1:0]  storeSlot;                 // Wide so overruns show
  logic [`HEAP_DATA_BITS-1:0]  storeValue;
  logic [`HEAP_SIZE_BITS-1:0]  indexPlusOne;

  assign row          = rows[cmd.array];
  assign size         = sizes[cmd.array];
  assign indexPlusOne = {1'b0, cmd.index} + 1'b1;
  assign isArith      = cmd.op inside {opAdd, opAddAfter, opSub, opSubAfter,
                                       opShiftLeft, opShiftRight,
                                       opOr, opXor, opAnd, opNot};

  // --------------------
  // Element write select
  // --------------------
  always_comb begin
    storeEnable = 1'b0;
    storeSlot   = {1'b0, cmd.index};
    storeValue  = cmd.data;
    if (commit) begin
      if (cmd.op == opWrite) begin
        storeEnable = 1'b1;
      end else if (cmd.op == opPush) begin
        storeEnable = 1'b1;
        storeSlot   = size;                               // Append after last
      end else if (isArith) begin
        storeEnable = 1'b1;
        storeValue  = aluValue;                           // Updated element
      end
    end
  end

  always_ff @(posedge clock) begin
    if (storeEnable) begin
      rows[cmd.array][storeSlot[`HEAP_INDEX_BITS-1:0]] <= storeValue;
    end
  end

  // --------------------
  // Size table
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else if (commit) begin
      case (cmd.op)
        opAlloc: sizes[allocNumber] <= '0;                // New array starts empty
        opWrite: begin
          if (indexPlusOne > size) begin
            sizes[cmd.array] <= indexPlusOne;             // Grow to cover index
          end
        end
        opPush:  sizes[cmd.array] <= size + 1'b1;
        opPop:   sizes[cmd.array] <= size - 1'b1;
        default: ;                                        // Size unchanged
      endcase
    end
  end

  // Full and bounds checks in the top keep every store inside the row
  storeInRow: assert property (@(posedge clock) disable iff (!resetN)
    storeEnable |-> storeSlot < `HEAP_ARRAY_LENGTH);

endmodule

/* verilog/heapAllocator.sv */
/*
  Array allocator
  Tracks which arrays are live, hands out freed arrays LIFO before
  fresh ones, and reports when no array is left
*/

`timescale 1ns/1ps
`include "heap_cfg.svh"

module heapAllocator import heapPkg::*; (
  input  logic                         clock,
  input  logic                         resetN,
  input  heapCmd_t                     cmd,
  input  logic                         commit,            // Command passed all checks
  output logic [`HEAP_ARRAY_BITS-1:0]  allocNumber,       // Array an Alloc would get
  output logic                         allocFail,         // Nothing left to hand out
  output logic                         isFresh,           // cmd.array never handed out
  output logic                         isAllocated        // cmd.array currently live
);

  logic [`HEAP_ARRAY_BITS-1:0] freedStack [`HEAP_ARRAYS];  // Freed arrays, LIFO
  logic [`HEAP_ARRAY_BITS:0]   stackTop;                  // Entries on the stack
  logic [`HEAP_ARRAY_BITS:0]   topBelow;                  // Slot of the newest entry
  logic [`HEAP_ARRAY_BITS:0]   freshCount;                // Next never-used array
  logic [`HEAP_ARRAYS-1:0]     allocBits;                 // One bit per live array
  logic                        doClear;
  logic                        doAlloc;
  logic                        doFree;
  logic                        stackEmpty;

  assign doClear    = commit && cmd.op == opClear;
  assign doAlloc    = commit && cmd.op == opAlloc;
  assign doFree     = commit && cmd.op == opFree;
  assign stackEmpty = stackTop == '0;
  assign topBelow   = stackTop - 1'b1;

  // --------------------
  // Status seen by the top
  // --------------------
  assign allocNumber = stackEmpty ? freshCount[`HEAP_ARRAY_BITS-1:0]
                                  : freedStack[topBelow[`HEAP_ARRAY_BITS-1:0]];
  assign allocFail   = stackEmpty && freshCount[`HEAP_ARRAY_BITS];  // MSB set when all used
  assign isFresh     = {1'b0, cmd.array} >= freshCount;
  assign isAllocated = allocBits[cmd.array];

  // --------------------
  // Control state
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stackTop   <= '0;
      freshCount <= '0;
      allocBits  <= '0;
    end else if (doClear) begin                           // Forget every array
      stackTop   <= '0;
      freshCount <= '0;
      allocBits  <= '0;
    end else if (doAlloc) begin
      if (stackEmpty) begin
        freshCount <= freshCount + 1'b1;                  // Take a fresh array
      end else begin
        stackTop <= topBelow;                             // Reuse newest freed
      end
      allocBits[allocNumber] <= 1'b1;
    end else if (doFree) begin
      stackTop               <= stackTop + 1'b1;
      allocBits[cmd.array]   <= 1'b0;
    end
  end

  // Push a freed array number
  always_ff @(posedge clock) begin
    if (doFree) begin
      freedStack[stackTop[`HEAP_ARRAY_BITS-1:0]] <= cmd.array;
    end
  end

  // Double free is rejected upstream, so the stack cannot overflow
  stackBound: assert property (@(posedge clock) disable iff (!resetN)
    doFree |=> stackTop <= `HEAP_ARRAYS);

endmodule

/* verilog/heapPkg.sv */
/*
  Array heap types
  Opcodes, error codes and the command, response and row structs
*/

`include "heap_cfg.svh"

package heapPkg;

  // --------------------
  // Opcodes and errors
  // --------------------
  typedef enum logic [4:0] {
    opNop, opClear, opAlloc, opFree,                      // Heap management
    opWrite, opRead, opSize,                              // Element access
    opPush, opPop,                                        // Stack use of an array
    opIndex, opLess, opGreater,                           // Searches over live elements
    opAdd, opAddAfter, opSub, opSubAfter,                 // Arithmetic in place
    opShiftLeft, opShiftRight,
    opOr, opXor, opAnd, opNot                             // Bitwise in place
  } heapOp_t;

  typedef enum logic [2:0] {
    errNone,                                              // Command accepted
    errNotAllocated,                                      // Number never handed out
    errFreed,                                             // Array is on the freed stack
    errOutOfBounds,                                       // Index at or past size
    errFull,                                              // Push on a full array
    errEmpty,                                             // Pop on an empty array
    errNoMemory                                           // Alloc with nothing left
  } heapError_t;

  // --------------------
  // Bus structs
  // --------------------
  typedef struct packed {
    heapOp_t                      op;                     // What to do
    logic [`HEAP_ARRAY_BITS-1:0]  array;                  // Target array
    logic [`HEAP_INDEX_BITS-1:0]  index;                  // Element within it
    logic [`HEAP_DATA_BITS-1:0]   data;                   // Value, key or operand
  } heapCmd_t;

  typedef struct packed {
    logic [`HEAP_DATA_BITS-1:0] data;                     // Returned value
    heapError_t                 error;                    // Outcome of last command
  } heapResp_t;

  // One whole array, element 0 in the low bits
  typedef logic [`HEAP_ARRAY_LENGTH-1:0][`HEAP_DATA_BITS-1:0] heapRow_t;

endpackage

/* verilog/heap_cfg.svh */
/*
  Array heap configuration
  Widths of array numbers, element indices and elements, and the counts
  that follow from them
*/

`ifndef HEAP_CFG_SVH
`define HEAP_CFG_SVH

// --------------------
// Base widths
// --------------------
`define HEAP_ARRAY_BITS 2                                 // Bits in an array number
`define HEAP_INDEX_BITS 2                                 // Bits in an element index
`define HEAP_DATA_BITS 12                                 // Bits in one element

// --------------------
// Derived counts
// --------------------
`define HEAP_ARRAYS (1 << `HEAP_ARRAY_BITS)               // Arrays in the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)         // Elements per array
`define HEAP_SIZE_BITS (`HEAP_INDEX_BITS + 1)             // Holds 0 up to a full array

`endif
